//--- Bender.yml
package:
  name: csu

sources:
  - include_dirs:
      - design
    files:
      - design/csu_types_pkg.sv
      - design/csu_ctrl_pkg.sv
      - design/csu_decoder.sv
      - design/csu_pipe.sv
      - design/csr_file.sv
      - design/csu_regfile.sv
      - design/csu_top.sv
  - target: test
    files:
      - tests/csu_tb.sv

//--- csu_top.f
+incdir+design
design/csu_types_pkg.sv
design/csu_ctrl_pkg.sv
design/csu_decoder.sv
design/csu_pipe.sv
design/csr_file.sv
design/csu_regfile.sv
design/csu_top.sv
tests/csu_tb.sv

//--- design/csr_file.sv
`timescale 1ns/1ps

/*
 * Machine-mode CSR file
 * Holds mstatus, mscratch, mepc and mtvec and returns misa and mhartid.
 * Unknown addresses flag a read error, writes to read-only ones a write error.
 */

`include "csu_cfg.svh"

module csr_file
  import csu_types_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  // read port
  input  csr_addr_t i_rd_addr,
  output xlen_t     o_rd_data,
  output logic      o_rd_error,
  // write port
  input  logic      i_wr_valid,
  input  csr_addr_t i_wr_addr,
  input  xlen_t     i_wr_data,
  output logic      o_wr_error,
  // status
  output logic      o_mstatus_tsr
);

  xlen_t r_mstatus;
  xlen_t r_mscratch;
  xlen_t r_mepc;
  xlen_t r_mtvec;

  // --------------------
  // read
  // --------------------
  always_comb begin
    o_rd_error = 1'b0;
    case (i_rd_addr)
      `CSU_ADDR_MSTATUS:  o_rd_data = r_mstatus;
      `CSU_ADDR_MISA:     o_rd_data = `CSU_MISA_VALUE;
      `CSU_ADDR_MTVEC:    o_rd_data = r_mtvec;
      `CSU_ADDR_MSCRATCH: o_rd_data = r_mscratch;
      `CSU_ADDR_MEPC:     o_rd_data = r_mepc;
      `CSU_ADDR_MHARTID:  o_rd_data = `CSU_HARTID_VALUE;
      default: begin
        o_rd_data  = '0;
        o_rd_error = 1'b1;
      end
    endcase
  end

  // --------------------
  // write
  // --------------------
  assign o_wr_error = i_wr_valid &
                      ((i_wr_addr == `CSU_ADDR_MISA) | (i_wr_addr == `CSU_ADDR_MHARTID));

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mstatus  <= '0;
      r_mscratch <= '0;
      r_mepc     <= '0;
      r_mtvec    <= '0;
    end else if (i_wr_valid) begin
      case (i_wr_addr)
        // only the implemented mstatus fields stick
        `CSU_ADDR_MSTATUS:  r_mstatus  <= i_wr_data & `CSU_MSTATUS_MASK;
        `CSU_ADDR_MTVEC:    r_mtvec    <= i_wr_data;
        `CSU_ADDR_MSCRATCH: r_mscratch <= i_wr_data;
        `CSU_ADDR_MEPC:     r_mepc     <= i_wr_data;
        default: ;
      endcase
    end
  end

  // trap SRET from S mode
  assign o_mstatus_tsr = r_mstatus[`CSU_MSTATUS_TSR];

endmodule

//--- design/csu_cfg.svh
/*
 * CSU configuration
 * Widths, CSR addresses and reset constants shared by the CSR access unit.
 */
`ifndef CSU_CFG_SVH
`define CSU_CFG_SVH

// widths and depths
`define CSU_XLEN          32
`define CSU_RNID_W        5
`define CSU_RF_DEPTH      32

// implemented machine-mode CSRs
`define CSU_ADDR_MSTATUS  12'h300
`define CSU_ADDR_MISA     12'h301
`define CSU_ADDR_MTVEC    12'h305
`define CSU_ADDR_MSCRATCH 12'h340
`define CSU_ADDR_MEPC     12'h341
`define CSU_ADDR_MHARTID  12'hf14

// mstatus fields
`define CSU_MSTATUS_TSR   22
// SIE MIE SPIE MPIE SPP MPP MPRV SUM MXR TVM TW TSR
`define CSU_MSTATUS_MASK  32'h007e_19aa

// read-only values, RV32 with I M A S U
`define CSU_MISA_VALUE    32'h4014_1101
`define CSU_HARTID_VALUE  32'h0000_0000

`endif

//--- design/csu_ctrl_pkg.sv
/*
 * CSU control types
 * CSR operation, privilege level and exception encodings.
 */

package csu_ctrl_pkg;

  // CSR read-modify-write flavour
  typedef enum logic [1:0] {
    OP_NONE = 2'd0,
    OP_RW   = 2'd1,
    OP_RS   = 2'd2,
    OP_RC   = 2'd3
  } csr_op_t;

  // privilege levels, H mode not present
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_t;

  // done report exception types, trap causes where one exists
  typedef enum logic [3:0] {
    ILLEGAL_INST = 4'd2,
    MRET         = 4'd12,
    SRET         = 4'd13,
    ECALL_U      = 4'd8,
    ECALL_S      = 4'd9,
    ECALL_M      = 4'd11,
    BREAKPOINT   = 4'd3,
    SILENT_FLUSH = 4'd15
  } except_t;

endpackage

//--- design/csu_decoder.sv
`timescale 1ns/1ps

/*
 * CSU decoder
 * Turns a system instruction into the control bits of the CSR pipeline.
 */
module csu_decoder
  import csu_types_pkg::*;
  import csu_ctrl_pkg::*;
(
  input  inst_t   i_inst,
  output csr_op_t o_op,
  output logic    o_rs1_is_reg,
  output logic    o_is_mret,
  output logic    o_is_sret,
  output logic    o_is_ecall,
  output logic    o_is_ebreak,
  output logic    o_csr_update
);

  localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

  logic       w_is_system;
  logic [2:0] w_funct3;

  assign w_is_system = (i_inst[6:0] == SYSTEM_OPCODE);
  assign w_funct3    = i_inst[14:12];

  // funct3 low bits select the operation, bit 2 the immediate form
  always_comb begin
    o_op = OP_NONE;
    if (w_is_system) begin
      case (w_funct3[1:0])
        2'b01:   o_op = OP_RW;
        2'b10:   o_op = OP_RS;
        2'b11:   o_op = OP_RC;
        default: o_op = OP_NONE;
      endcase
    end
  end

  assign o_csr_update = (o_op != OP_NONE);
  assign o_rs1_is_reg = o_csr_update & ~w_funct3[2];

  // privileged forms have fixed encodings
  assign o_is_ecall  = (i_inst == 32'h0000_0073);
  assign o_is_ebreak = (i_inst == 32'h0010_0073);
  assign o_is_sret   = (i_inst == 32'h1020_0073);
  assign o_is_mret   = (i_inst == 32'h3020_0073);

endmodule

//--- design/csu_pipe.sv
`timescale 1ns/1ps

/*
 * CSU pipeline
 * ex0 decode, ex1 rs1 read, ex2 CSR read and new value,
 * ex3 CSR write, old value writeback and done report.
 */
module csu_pipe
  import csu_types_pkg::*;
  import csu_ctrl_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  // issue
  input  logic      i_issue_valid,
  input  inst_t     i_issue_inst,
  input  cmt_id_t   i_issue_cmt_id,
  input  rnid_t     i_issue_rs1_rnid,
  input  rnid_t     i_issue_rd_rnid,
  // register read
  output rnid_t     o_rs1_rnid,
  input  xlen_t     i_rs1_data,
  // CSR access
  output csr_addr_t o_csr_rd_addr,
  input  xlen_t     i_csr_rd_data,
  input  logic      i_csr_rd_error,
  output logic      o_csr_wr_valid,
  output csr_addr_t o_csr_wr_addr,
  output xlen_t     o_csr_wr_data,
  input  logic      i_csr_wr_error,
  input  logic      i_mstatus_tsr,
  input  priv_t     i_priv,
  // writeback
  output logic      o_phy_wr_valid,
  output rnid_t     o_phy_wr_rnid,
  output xlen_t     o_phy_wr_data,
  // done report
  output logic      o_done_valid,
  output cmt_id_t   o_done_cmt_id,
  output logic      o_done_except_valid,
  output except_t   o_done_except_type,
  output xlen_t     o_done_except_tval
);

  logic    r_ex0_valid;
  inst_t   r_ex0_inst;
  cmt_id_t r_ex0_cmt_id;
  rnid_t   r_ex0_rs1_rnid;
  rnid_t   r_ex0_rd_rnid;
  csr_op_t w_ex0_op;
  logic    w_ex0_rs1_is_reg;
  logic    w_ex0_is_mret;
  logic    w_ex0_is_sret;
  logic    w_ex0_is_ecall;
  logic    w_ex0_is_ebreak;
  logic    w_ex0_csr_update;

  logic    r_ex1_valid;
  logic    r_ex2_valid;
  logic    r_ex3_valid;
  inst_t   r_ex1_inst;
  inst_t   r_ex2_inst;
  inst_t   r_ex3_inst;
  cmt_id_t r_ex1_cmt_id;
  cmt_id_t r_ex2_cmt_id;
  cmt_id_t r_ex3_cmt_id;
  rnid_t   r_ex1_rs1_rnid;
  rnid_t   r_ex1_rd_rnid;
  rnid_t   r_ex2_rd_rnid;
  rnid_t   r_ex3_rd_rnid;
  csr_op_t r_ex1_op;
  csr_op_t r_ex2_op;
  csr_op_t r_ex3_op;
  logic    r_ex1_rs1_is_reg;
  logic    r_ex2_rs1_is_reg;
  logic    r_ex1_csr_update;
  logic    r_ex2_csr_update;
  logic    r_ex3_csr_update;
  // privileged flags, ex1..ex3
  logic [3:1] r_is_mret;
  logic [3:1] r_is_sret;
  logic [3:1] r_is_ecall;
  logic [3:1] r_is_ebreak;

  xlen_t   r_ex2_rs1_data;
  xlen_t   w_ex2_operand;
  xlen_t   w_ex2_result;
  xlen_t   r_ex3_result;
  xlen_t   r_ex3_old;
  logic    r_ex3_rd_error;
  logic    w_ex3_illegal;
  logic    w_ex3_rs1_zero;

  csu_decoder u_decoder (
    .i_inst       (r_ex0_inst),
    .o_op         (w_ex0_op),
    .o_rs1_is_reg (w_ex0_rs1_is_reg),
    .o_is_mret    (w_ex0_is_mret),
    .o_is_sret    (w_ex0_is_sret),
    .o_is_ecall   (w_ex0_is_ecall),
    .o_is_ebreak  (w_ex0_is_ebreak),
    .o_csr_update (w_ex0_csr_update)
  );

  // valid chain
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid    <= 1'b0;
      r_ex1_valid    <= 1'b0;
      r_ex2_valid    <= 1'b0;
      r_ex3_valid    <= 1'b0;
      r_ex3_rd_error <= 1'b0;
    end else begin
      r_ex0_valid    <= i_issue_valid;
      r_ex1_valid    <= r_ex0_valid;
      r_ex2_valid    <= r_ex1_valid;
      r_ex3_valid    <= r_ex2_valid;
      r_ex3_rd_error <= r_ex2_valid & r_ex2_csr_update & i_csr_rd_error;
    end
  end

  // instruction and decoded fields follow the valid chain
  always_ff @(posedge i_clk) begin
    r_ex0_inst       <= i_issue_inst;
    r_ex0_cmt_id     <= i_issue_cmt_id;
    r_ex0_rs1_rnid   <= i_issue_rs1_rnid;
    r_ex0_rd_rnid    <= i_issue_rd_rnid;
    r_ex1_inst       <= r_ex0_inst;
    r_ex1_cmt_id     <= r_ex0_cmt_id;
    r_ex1_rs1_rnid   <= r_ex0_rs1_rnid;
    r_ex1_rd_rnid    <= r_ex0_rd_rnid;
    r_ex1_op         <= w_ex0_op;
    r_ex1_rs1_is_reg <= w_ex0_rs1_is_reg;
    r_ex1_csr_update <= w_ex0_csr_update;
    r_is_mret        <= {r_is_mret[2:1], w_ex0_is_mret};
    r_is_sret        <= {r_is_sret[2:1], w_ex0_is_sret};
    r_is_ecall       <= {r_is_ecall[2:1], w_ex0_is_ecall};
    r_is_ebreak      <= {r_is_ebreak[2:1], w_ex0_is_ebreak};
    r_ex2_inst       <= r_ex1_inst;
    r_ex2_cmt_id     <= r_ex1_cmt_id;
    r_ex2_rd_rnid    <= r_ex1_rd_rnid;
    r_ex2_op         <= r_ex1_op;
    r_ex2_rs1_is_reg <= r_ex1_rs1_is_reg;
    r_ex2_csr_update <= r_ex1_csr_update;
    r_ex2_rs1_data   <= i_rs1_data;
    r_ex3_inst       <= r_ex2_inst;
    r_ex3_cmt_id     <= r_ex2_cmt_id;
    r_ex3_rd_rnid    <= r_ex2_rd_rnid;
    r_ex3_op         <= r_ex2_op;
    r_ex3_csr_update <= r_ex2_csr_update;
    r_ex3_result     <= w_ex2_result;
    r_ex3_old        <= i_csr_rd_data;
  end

  // ex1 register read
  assign o_rs1_rnid = r_ex1_rs1_rnid;

  // --------------------
  // ex2 CSR read
  // --------------------
  assign o_csr_rd_addr = r_ex2_inst[31:20];

  // zimm for the immediate forms
  assign w_ex2_operand = r_ex2_rs1_is_reg ? r_ex2_rs1_data : xlen_t'(r_ex2_inst[19:15]);

  always_comb begin
    case (r_ex2_op)
      OP_RW:   w_ex2_result = w_ex2_operand;
      OP_RS:   w_ex2_result = i_csr_rd_data | w_ex2_operand;
      OP_RC:   w_ex2_result = i_csr_rd_data & ~w_ex2_operand;
      default: w_ex2_result = '0;
    endcase
  end

  // --------------------
  // ex3 update and report
  // --------------------
  assign w_ex3_rs1_zero = (r_ex3_inst[19:15] == 5'd0);

  // set/clear with x0 or zimm 0 only reads
  assign o_csr_wr_valid = r_ex3_valid & r_ex3_csr_update & ~r_ex3_rd_error &
                          ~(((r_ex3_op == OP_RS) | (r_ex3_op == OP_RC)) & w_ex3_rs1_zero);
  assign o_csr_wr_addr  = r_ex3_inst[31:20];
  assign o_csr_wr_data  = r_ex3_result;

  assign w_ex3_illegal = r_ex3_rd_error | i_csr_wr_error | (r_is_sret[3] & i_mstatus_tsr);

  // old value to rd, never to x0
  assign o_phy_wr_valid = r_ex3_valid & r_ex3_csr_update & ~w_ex3_illegal &
                          (r_ex3_inst[11:7] != 5'd0);
  assign o_phy_wr_rnid  = r_ex3_rd_rnid;
  assign o_phy_wr_data  = r_ex3_old;

  assign o_done_valid        = r_ex3_valid;
  assign o_done_cmt_id       = r_ex3_cmt_id;
  assign o_done_except_valid = r_ex3_valid & (r_ex3_csr_update | r_is_mret[3] | r_is_sret[3] |
                                              r_is_ecall[3] | r_is_ebreak[3] | w_ex3_illegal);

  assign o_done_except_type =
      w_ex3_illegal                       ? ILLEGAL_INST :
      r_is_mret[3]                        ? MRET :
      r_is_sret[3]                        ? SRET :
      r_is_ecall[3] & (i_priv == PRIV_U)  ? ECALL_U :
      r_is_ecall[3] & (i_priv == PRIV_S)  ? ECALL_S :
      r_is_ecall[3]                       ? ECALL_M :
      r_is_ebreak[3]                      ? BREAKPOINT :
                                            SILENT_FLUSH;

  assign o_done_except_tval = w_ex3_illegal ? r_ex3_inst : '0;

endmodule

//--- design/csu_regfile.sv
`timescale 1ns/1ps

/*
 * Physical register file
 * Flop array with a combinational read port, a preload write port
 * and a writeback port that wins on a same-entry collision.
 */

`include "csu_cfg.svh"

module csu_regfile
  import csu_types_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,
  input  rnid_t i_rd_rnid,
  output xlen_t o_rd_data,
  input  logic  i_pre_wr_valid,
  input  rnid_t i_pre_wr_rnid,
  input  xlen_t i_pre_wr_data,
  input  logic  i_wb_wr_valid,
  input  rnid_t i_wb_wr_rnid,
  input  xlen_t i_wb_wr_data
);

  xlen_t r_regs [`CSU_RF_DEPTH];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `CSU_RF_DEPTH; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      if (i_pre_wr_valid) begin
        r_regs[i_pre_wr_rnid] <= i_pre_wr_data;
      end
      // later assignment takes priority
      if (i_wb_wr_valid) begin
        r_regs[i_wb_wr_rnid] <= i_wb_wr_data;
      end
    end
  end

  assign o_rd_data = r_regs[i_rd_rnid];

endmodule

//--- design/csu_top.sv
`timescale 1ns/1ps

/*
 * CSU top
 * CSR access pipeline with its CSR file and physical register file.
 */
module csu_top
  import csu_types_pkg::*;
  import csu_ctrl_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  // issue
  input  logic    i_issue_valid,
  input  inst_t   i_issue_inst,
  input  cmt_id_t i_issue_cmt_id,
  input  rnid_t   i_issue_rs1_rnid,
  input  rnid_t   i_issue_rd_rnid,
  // register preload
  input  logic    i_pre_wr_valid,
  input  rnid_t   i_pre_wr_rnid,
  input  xlen_t   i_pre_wr_data,
  input  priv_t   i_priv,
  // writeback
  output logic    o_phy_wr_valid,
  output rnid_t   o_phy_wr_rnid,
  output xlen_t   o_phy_wr_data,
  // done report
  output logic    o_done_valid,
  output cmt_id_t o_done_cmt_id,
  output logic    o_done_except_valid,
  output except_t o_done_except_type,
  output xlen_t   o_done_except_tval
);

  rnid_t     w_rs1_rnid;
  xlen_t     w_rs1_data;
  csr_addr_t w_csr_rd_addr;
  xlen_t     w_csr_rd_data;
  logic      w_csr_rd_error;
  logic      w_csr_wr_valid;
  csr_addr_t w_csr_wr_addr;
  xlen_t     w_csr_wr_data;
  logic      w_csr_wr_error;
  logic      w_mstatus_tsr;

  csu_pipe u_pipe (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_issue_valid       (i_issue_valid),
    .i_issue_inst        (i_issue_inst),
    .i_issue_cmt_id      (i_issue_cmt_id),
    .i_issue_rs1_rnid    (i_issue_rs1_rnid),
    .i_issue_rd_rnid     (i_issue_rd_rnid),
    .o_rs1_rnid          (w_rs1_rnid),
    .i_rs1_data          (w_rs1_data),
    .o_csr_rd_addr       (w_csr_rd_addr),
    .i_csr_rd_data       (w_csr_rd_data),
    .i_csr_rd_error      (w_csr_rd_error),
    .o_csr_wr_valid      (w_csr_wr_valid),
    .o_csr_wr_addr       (w_csr_wr_addr),
    .o_csr_wr_data       (w_csr_wr_data),
    .i_csr_wr_error      (w_csr_wr_error),
    .i_mstatus_tsr       (w_mstatus_tsr),
    .i_priv              (i_priv),
    .o_phy_wr_valid      (o_phy_wr_valid),
    .o_phy_wr_rnid       (o_phy_wr_rnid),
    .o_phy_wr_data       (o_phy_wr_data),
    .o_done_valid        (o_done_valid),
    .o_done_cmt_id       (o_done_cmt_id),
    .o_done_except_valid (o_done_except_valid),
    .o_done_except_type  (o_done_except_type),
    .o_done_except_tval  (o_done_except_tval)
  );

  csr_file u_csr_file (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rd_addr     (w_csr_rd_addr),
    .o_rd_data     (w_csr_rd_data),
    .o_rd_error    (w_csr_rd_error),
    .i_wr_valid    (w_csr_wr_valid),
    .i_wr_addr     (w_csr_wr_addr),
    .i_wr_data     (w_csr_wr_data),
    .o_wr_error    (w_csr_wr_error),
    .o_mstatus_tsr (w_mstatus_tsr)
  );

  // writeback goes out and back into the register file
  csu_regfile u_regfile (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_rd_rnid      (w_rs1_rnid),
    .o_rd_data      (w_rs1_data),
    .i_pre_wr_valid (i_pre_wr_valid),
    .i_pre_wr_rnid  (i_pre_wr_rnid),
    .i_pre_wr_data  (i_pre_wr_data),
    .i_wb_wr_valid  (o_phy_wr_valid),
    .i_wb_wr_rnid   (o_phy_wr_rnid),
    .i_wb_wr_data   (o_phy_wr_data)
  );

endmodule

//--- design/csu_types_pkg.sv
/*
 * CSU data types
 * Plain vector types for the data, address and id widths of the unit.
 */

`include "csu_cfg.svh"

package csu_types_pkg;

  // architectural data word
  typedef logic [`CSU_XLEN-1:0] xlen_t;

  // CSR address field of a system instruction
  typedef logic [11:0] csr_addr_t;

  // physical register id
  typedef logic [`CSU_RNID_W-1:0] rnid_t;

  // commit id returned with the done report
  typedef logic [5:0] cmt_id_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

endpackage

//--- tests/csu_cases.txt
# P rnid data  (hex)
# I name inst cmt_id rs1_rnid rd_rnid priv wb_valid wb_data except_valid except_type tval (hex)
P 01 12345678
P 02 0000ff00
P 03 00000f0f
P 04 00400000
P 05 ffffffff
I rw_mscratch      34009573 20 01 0a 3 1 00000000 1 f 00000000
I rs_mscratch_x0   340025f3 21 00 0b 3 1 12345678 1 f 00000000
I rs_misa_x0       301026f3 22 00 0d 3 1 40141101 1 f 00000000
I rs_mhartid_x0    f1402773 23 00 0e 3 1 00000000 1 f 00000000
I rw_mepc          341117f3 24 02 0f 3 1 00000000 1 f 00000000
I rs_mepc_reg      3411a873 25 03 10 3 1 0000ff00 1 f 00000000
I rc_mepc_reg      341138f3 26 02 11 3 1 0000ff0f 1 f 00000000
I rsi_mepc         34186973 27 00 12 3 1 0000000f 1 f 00000000
I rci_mepc         3411f9f3 28 00 13 3 1 0000001f 1 f 00000000
I rs_mepc_read     34102a73 29 00 14 3 1 0000001c 1 f 00000000
I rw_mstatus_all   30029af3 2a 05 15 3 1 00000000 1 f 00000000
I rw_mstatus_clear 30001b73 2b 00 16 3 1 007e19aa 1 f 00000000
I rw_misa_ill      30109bf3 2c 01 17 3 0 00000000 1 2 30109bf3
I rw_mhartid_ill   f1409c73 2d 01 18 3 0 00000000 1 2 f1409c73
I rs_unknown_ill   7c002cf3 2e 00 19 3 0 00000000 1 2 7c002cf3
I ecall_u          00000073 2f 00 00 0 0 00000000 1 8 00000000
I ecall_s          00000073 30 00 00 1 0 00000000 1 9 00000000
I ecall_m          00000073 31 00 00 3 0 00000000 1 b 00000000
I ebreak           00100073 32 00 00 3 0 00000000 1 3 00000000
I mret             30200073 33 00 00 3 0 00000000 1 c 00000000
I sret_ok          10200073 34 00 00 1 0 00000000 1 d 00000000
I rs_mstatus_tsr   30022d73 35 04 1a 3 1 00000000 1 f 00000000
I sret_tsr_ill     10200073 36 00 00 1 0 00000000 1 2 10200073
I rw_mscratch_x0   34019073 37 03 1f 3 0 00000000 1 f 00000000
I rs_mscratch_back 34002df3 38 00 1b 3 1 00000f0f 1 f 00000000
I addi_plain       00100093 39 00 1e 3 0 00000000 0 0 00000000

//--- tests/csu_tb.sv
`timescale 1ns/1ps

/*
 * CSU testbench
 * Reads register preloads and instruction cases from a text file, issues
 * each instruction to the CSU and checks its writeback and done report.
 */
module csu_tb
  import csu_types_pkg::*;
  import csu_ctrl_pkg::*;
();

  localparam int MAX_CASES     = 64;
  // rising edges from the issue drive to the done sample for a latency of 3
  localparam int DONE_EDGES    = 4;
  localparam int DONE_WAIT_MAX = 8;

  logic    clk;
  logic    reset_n;
  logic    issue_valid;
  inst_t   issue_inst;
  cmt_id_t issue_cmt_id;
  rnid_t   issue_rs1_rnid;
  rnid_t   issue_rd_rnid;
  logic    pre_wr_valid;
  rnid_t   pre_wr_rnid;
  xlen_t   pre_wr_data;
  priv_t   priv;
  logic    phy_wr_valid;
  rnid_t   phy_wr_rnid;
  xlen_t   phy_wr_data;
  logic    done_valid;
  cmt_id_t done_cmt_id;
  logic    done_except_valid;
  except_t done_except_type;
  xlen_t   done_except_tval;

  // case table
  // preload lines reuse rd and wb_data
  logic    case_is_pre   [MAX_CASES];
  string   case_name     [MAX_CASES];
  inst_t   case_inst     [MAX_CASES];
  cmt_id_t case_cmt      [MAX_CASES];
  rnid_t   case_rs1      [MAX_CASES];
  rnid_t   case_rd       [MAX_CASES];
  priv_t   case_priv     [MAX_CASES];
  logic    case_wb_valid [MAX_CASES];
  xlen_t   case_wb_data  [MAX_CASES];
  logic    case_ex_valid [MAX_CASES];
  except_t case_ex_type  [MAX_CASES];
  xlen_t   case_tval     [MAX_CASES];
  int      case_count  = 0;
  int      cycle_limit = 0;
  int      cycle_count = 0;

  csu_top u_csu_top (
    .i_clk               (clk),
    .i_reset_n           (reset_n),
    .i_issue_valid       (issue_valid),
    .i_issue_inst        (issue_inst),
    .i_issue_cmt_id      (issue_cmt_id),
    .i_issue_rs1_rnid    (issue_rs1_rnid),
    .i_issue_rd_rnid     (issue_rd_rnid),
    .i_pre_wr_valid      (pre_wr_valid),
    .i_pre_wr_rnid       (pre_wr_rnid),
    .i_pre_wr_data       (pre_wr_data),
    .i_priv              (priv),
    .o_phy_wr_valid      (phy_wr_valid),
    .o_phy_wr_rnid       (phy_wr_rnid),
    .o_phy_wr_data       (phy_wr_data),
    .o_done_valid        (done_valid),
    .o_done_cmt_id       (done_cmt_id),
    .o_done_except_valid (done_except_valid),
    .o_done_except_type  (done_except_type),
    .o_done_except_tval  (done_except_tval)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // failure and compares
  // --------------------
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_xlen(input string name, input string what,
                            input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s %s expected %08h actual %08h", name, what, exp, act));
    end
  endtask

  task automatic check_except(input string name, input except_t exp, input except_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s except_type expected %s (%0d) actual %0d",
                         name, exp.name(), exp, act));
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s %s expected %b actual %b", name, what, exp, act));
    end
  endtask

  task automatic check_cmt(input string name, input cmt_id_t exp, input cmt_id_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s cmt_id expected %02h actual %02h", name, exp, act));
    end
  endtask

  task automatic check_rnid(input string name, input rnid_t exp, input rnid_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s wb_rnid expected %02h actual %02h", name, exp, act));
    end
  endtask

  // --------------------
  // case file
  // --------------------
  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       kind;
    string       name;
    logic [31:0] t_inst, t_cmt, t_rs1, t_rd, t_priv;
    logic [31:0] t_wbv, t_wbd, t_exv, t_ext, t_tval;
    fd = $fopen("tests/csu_cases.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the case file tests/csu_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        if (case_count >= MAX_CASES) begin
          fail_run("too many lines in the case file");
        end
        n = $sscanf(line, "%s", kind);
        if (kind == "P") begin
          n = $sscanf(line, "%s %h %h", kind, t_rd, t_wbd);
          if (n != 3) begin
            fail_run($sformatf("malformed preload line: %s", line));
          end
          case_is_pre[case_count]  = 1'b1;
          case_name[case_count]    = "preload";
          case_rd[case_count]      = rnid_t'(t_rd);
          case_wb_data[case_count] = t_wbd;
        end else begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", kind, name, t_inst,
                      t_cmt, t_rs1, t_rd, t_priv, t_wbv, t_wbd, t_exv, t_ext, t_tval);
          if (kind != "I" || n != 12) begin
            fail_run($sformatf("malformed instruction line: %s", line));
          end
          case_is_pre[case_count]   = 1'b0;
          case_name[case_count]     = name;
          case_inst[case_count]     = t_inst;
          case_cmt[case_count]      = cmt_id_t'(t_cmt);
          case_rs1[case_count]      = rnid_t'(t_rs1);
          case_rd[case_count]       = rnid_t'(t_rd);
          case_priv[case_count]     = priv_t'(t_priv[1:0]);
          case_wb_valid[case_count] = t_wbv[0];
          case_wb_data[case_count]  = t_wbd;
          case_ex_valid[case_count] = t_exv[0];
          case_ex_type[case_count]  = except_t'(t_ext[3:0]);
          case_tval[case_count]     = t_tval;
        end
        case_count++;
      end
    end
    $fclose(fd);
  endtask

  // --------------------
  // drivers
  // --------------------
  task automatic preload_reg(input int idx);
    pre_wr_valid = 1'b1;
    pre_wr_rnid  = case_rd[idx];
    pre_wr_data  = case_wb_data[idx];
    @(posedge clk);
    #1;
    pre_wr_valid = 1'b0;
    if (done_valid !== 1'b0 || phy_wr_valid !== 1'b0) begin
      fail_run("unexpected done or writeback strobe during a register preload");
    end
  endtask

  task automatic run_inst(input int idx);
    int    edges;
    logic  seen;
    string name;
    name           = case_name[idx];
    issue_valid    = 1'b1;
    issue_inst     = case_inst[idx];
    issue_cmt_id   = case_cmt[idx];
    issue_rs1_rnid = case_rs1[idx];
    issue_rd_rnid  = case_rd[idx];
    priv           = case_priv[idx];
    edges          = 0;
    seen           = 1'b0;
    while (!seen && edges < DONE_WAIT_MAX) begin
      @(posedge clk);
      #1;
      issue_valid = 1'b0;
      edges++;
      seen = (done_valid === 1'b1);
      if (!seen && phy_wr_valid !== 1'b0) begin
        fail_run($sformatf("%s: writeback strobe came before the done strobe", name));
      end
    end
    if (!seen) begin
      fail_run($sformatf("%s: no done strobe within %0d cycles", name, DONE_WAIT_MAX));
    end
    if (edges != DONE_EDGES) begin
      fail_run($sformatf("%s: done strobe %0d cycles after issue instead of %0d",
                         name, edges - 1, DONE_EDGES - 1));
    end
    check_cmt(name, case_cmt[idx], done_cmt_id);
    check_bit(name, "wb_valid", case_wb_valid[idx], phy_wr_valid);
    if (case_wb_valid[idx]) begin
      check_rnid(name, case_rd[idx], phy_wr_rnid);
      check_xlen(name, "wb_data", case_wb_data[idx], phy_wr_data);
    end
    check_bit(name, "except_valid", case_ex_valid[idx], done_except_valid);
    if (case_ex_valid[idx]) begin
      check_except(name, case_ex_type[idx], done_except_type);
    end
    check_xlen(name, "tval", case_tval[idx], done_except_tval);
  endtask

  // watchdog limit follows the number of cases
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      fail_run($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

  initial begin
    reset_n        = 1'b0;
    issue_valid    = 1'b0;
    issue_inst     = '0;
    issue_cmt_id   = '0;
    issue_rs1_rnid = '0;
    issue_rd_rnid  = '0;
    pre_wr_valid   = 1'b0;
    pre_wr_rnid    = '0;
    pre_wr_data    = '0;
    priv           = PRIV_M;
    load_cases();
    cycle_limit = case_count * 8 + 100;
    repeat (10) @(posedge clk);
    #1;
    reset_n = 1'b1;
    for (int i = 0; i < case_count; i++) begin
      if (case_is_pre[i]) begin
        preload_reg(i);
      end else begin
        run_inst(i);
      end
    end
    @(posedge clk);
    #1;
    if (done_valid !== 1'b0) begin
      fail_run("done strobe held longer than one cycle after the last case");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule
